// ==== rtl/vend_pkg.sv ====
`default_nettype none

package vend_pkg;

    // credit datapath
    localparam int credit_w = 7;
    localparam logic [credit_w-1:0] credit_max = 7'd95;

    // one returned coin
    localparam logic [credit_w-1:0] coin_unit = 7'd5;

    // amounts added by each coin button
    localparam logic [credit_w-1:0] coin_5_value = 7'd5;
    localparam logic [credit_w-1:0] coin_10_value = 7'd10;
    localparam logic [credit_w-1:0] coin_50_value = 7'd50;

    // bit 3 is A down to bit 0 is F
    localparam int n_drinks = 4;

    localparam logic [credit_w-1:0] price_a = 7'd60;
    localparam logic [credit_w-1:0] price_s = 7'd30;
    localparam logic [credit_w-1:0] price_d = 7'd25;
    localparam logic [credit_w-1:0] price_f = 7'd20;

    // keyboard make codes
    localparam logic [7:0] scan_a = 8'h1C;
    localparam logic [7:0] scan_s = 8'h1B;
    localparam logic [7:0] scan_d = 8'h23;
    localparam logic [7:0] scan_f = 8'h2B;

    // samples a button must stay high
    localparam int debounce_len = 8;

    // one coin per second at 100 MHz
    localparam int return_div_default = 100_000_000;
    localparam int scan_div_default = 100_000;

    // active low segments a..g, decimal point in bit 0 kept dark
    localparam logic [7:0] seg_table [0:9] = '{
        8'b0000_0011,
        8'b1001_1111,
        8'b0010_0101,
        8'b0000_1101,
        8'b1001_1001,
        8'b0100_1001,
        8'b0100_0001,
        8'b0001_1111,
        8'b0000_0001,
        8'b0000_1001
    };

endpackage

`default_nettype wire

// ==== rtl/debounce_pulse.sv ====
`timescale 1ns/1ns
`default_nettype none

module debounce_pulse (
    input  wire  clk,
    input  wire  rst,
    input  wire  sig,
    output logic pulse
);

    logic [vend_pkg::debounce_len-1:0] samples;
    logic level;
    logic level_d;

    // stable only when every sample is high
    assign level = &samples;

    always_ff @(posedge clk) begin
        if (rst) begin
            samples <= '0;
            level_d <= 1'b0;
            pulse <= 1'b0;
        end else begin
            samples <= {samples[vend_pkg::debounce_len-2:0], sig};
            level_d <= level;
            // one cycle on the rising edge of the clean level
            pulse <= level & ~level_d;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/tick_divider.sv ====
`timescale 1ns/1ns
`default_nettype none

module tick_divider #(
    parameter int DIV_COUNT = 16
) (
    input  wire  clk,
    input  wire  rst,
    input  wire  run,
    output logic tick
);

    localparam int cnt_w = (DIV_COUNT > 1) ? $clog2(DIV_COUNT) : 1;

    logic [cnt_w-1:0] cnt;
    logic wrap;

    assign wrap = (cnt == cnt_w'(DIV_COUNT - 1));

    always_ff @(posedge clk) begin
        if (rst || !run) begin
            // counter restarts with each new return
            cnt <= '0;
            tick <= 1'b0;
        end else begin
            tick <= wrap;
            if (wrap) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/key_selector.sv ====
`timescale 1ns/1ns
`default_nettype none

module key_selector (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           key_req,
    input  wire  [7:0]                    key_code,
    output logic                          key_ack,
    output logic [vend_pkg::n_drinks-1:0] select
);

    localparam logic st_idle = 1'b0;
    localparam logic st_ack = 1'b1;

    logic state;
    logic [vend_pkg::n_drinks-1:0] match;

    // unknown codes give an all-zero match
    assign match = {
        key_code == vend_pkg::scan_a,
        key_code == vend_pkg::scan_s,
        key_code == vend_pkg::scan_d,
        key_code == vend_pkg::scan_f
    };

    assign key_ack = (state == st_ack);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            select <= '0;
        end else begin
            select <= '0;
            case (state)
                st_idle: begin
                    // code is stable while req is high
                    if (key_req) begin
                        state <= st_ack;
                        select <= match;
                    end
                end
                st_ack: begin
                    // hold ack until the producer drops req
                    if (!key_req) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/vend_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module vend_core (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  add_5,
    input  wire                                  add_10,
    input  wire                                  add_50,
    input  wire                                  cancel,
    input  wire  [vend_pkg::n_drinks-1:0]        select,
    input  wire                                  return_tick,
    output logic [vend_pkg::credit_w-1:0]        credit,
    output logic [vend_pkg::n_drinks-1:0]        affordable,
    output logic [vend_pkg::n_drinks-1:0]        dispense,
    output logic                                 coin_out,
    output logic                                 busy
);

    localparam logic mode_insert = 1'b0;
    localparam logic mode_return = 1'b1;

    logic mode;
    logic [vend_pkg::n_drinks-1:0] pick;
    logic [vend_pkg::credit_w-1:0] price_sel;

    function automatic logic [vend_pkg::credit_w-1:0] sat_add(
        input logic [vend_pkg::credit_w-1:0] base,
        input logic [vend_pkg::credit_w-1:0] value
    );
        if (base > vend_pkg::credit_max - value) begin
            return vend_pkg::credit_max;
        end
        return base + value;
    endfunction

    assign affordable = {
        credit >= vend_pkg::price_a,
        credit >= vend_pkg::price_s,
        credit >= vend_pkg::price_d,
        credit >= vend_pkg::price_f
    };

    assign busy = (mode == mode_return);

    // first affordable selection wins, A down to F
    always_comb begin
        pick = '0;
        price_sel = '0;
        if (select[3] && affordable[3]) begin
            pick[3] = 1'b1;
            price_sel = vend_pkg::price_a;
        end else if (select[2] && affordable[2]) begin
            pick[2] = 1'b1;
            price_sel = vend_pkg::price_s;
        end else if (select[1] && affordable[1]) begin
            pick[1] = 1'b1;
            price_sel = vend_pkg::price_d;
        end else if (select[0] && affordable[0]) begin
            pick[0] = 1'b1;
            price_sel = vend_pkg::price_f;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mode <= mode_insert;
            credit <= '0;
            dispense <= '0;
            coin_out <= 1'b0;
        end else begin
            dispense <= '0;
            coin_out <= 1'b0;
            if (mode == mode_insert) begin
                if (add_5) begin
                    credit <= sat_add(credit, vend_pkg::coin_5_value);
                end else if (add_10) begin
                    credit <= sat_add(credit, vend_pkg::coin_10_value);
                end else if (add_50) begin
                    credit <= sat_add(credit, vend_pkg::coin_50_value);
                end else if (pick != '0) begin
                    credit <= credit - price_sel;
                    dispense <= pick;
                    // change goes back only if something is left
                    if (credit != price_sel) begin
                        mode <= mode_return;
                    end
                end else if (cancel && credit != '0) begin
                    mode <= mode_return;
                end
            end else if (return_tick) begin
                // pay back one coin per tick
                coin_out <= 1'b1;
                if (credit <= vend_pkg::coin_unit) begin
                    credit <= '0;
                    mode <= mode_insert;
                end else begin
                    credit <= credit - vend_pkg::coin_unit;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/coin_display.sv ====
`timescale 1ns/1ns
`default_nettype none

module coin_display #(
    parameter int SCAN_DIV = vend_pkg::scan_div_default
) (
    input  wire                           clk,
    input  wire                           rst,
    input  wire  [vend_pkg::credit_w-1:0] credit,
    output logic [7:0]                    seg,
    output logic [3:0]                    an
);

    localparam int cnt_w = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [cnt_w-1:0] scan_cnt;
    // 0 shows ones, 1 shows tens
    logic digit_sel;
    logic [3:0] tens;
    logic [3:0] ones;
    logic [3:0] digit;

    always_ff @(posedge clk) begin
        if (rst) begin
            scan_cnt <= '0;
            digit_sel <= 1'b0;
        end else if (scan_cnt == cnt_w'(SCAN_DIV - 1)) begin
            scan_cnt <= '0;
            digit_sel <= ~digit_sel;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // decimal split of the credit
    assign tens = 4'(credit / 10);
    assign ones = 4'(credit % 10);

    assign digit = digit_sel ? tens : ones;

    // anodes are active low
    assign an = digit_sel ? 4'b1101 : 4'b1110;

    always_comb begin
        if (digit <= 4'd9) begin
            seg = vend_pkg::seg_table[digit];
        end else begin
            // blank for anything past 9
            seg = 8'hff;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/vend_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module vend_top #(
    parameter int RETURN_DIV = vend_pkg::return_div_default,
    parameter int SCAN_DIV = vend_pkg::scan_div_default
) (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           coin_5,
    input  wire                           coin_10,
    input  wire                           coin_50,
    input  wire                           cancel,
    input  wire                           key_req,
    input  wire  [7:0]                    key_code,
    output logic                          key_ack,
    output logic [vend_pkg::n_drinks-1:0] dispense,
    output logic                          coin_out,
    output logic                          busy,
    output logic [vend_pkg::n_drinks-1:0] affordable,
    output logic [7:0]                    seg,
    output logic [3:0]                    an
);

    logic add_5;
    logic add_10;
    logic add_50;
    logic cancel_pulse;
    logic return_tick;
    logic [vend_pkg::n_drinks-1:0] select;
    logic [vend_pkg::credit_w-1:0] credit;

    // push-button cleanup
    debounce_pulse u_db_5 (.clk(clk), .rst(rst), .sig(coin_5), .pulse(add_5));
    debounce_pulse u_db_10 (.clk(clk), .rst(rst), .sig(coin_10), .pulse(add_10));
    debounce_pulse u_db_50 (.clk(clk), .rst(rst), .sig(coin_50), .pulse(add_50));
    debounce_pulse u_db_cancel (.clk(clk), .rst(rst), .sig(cancel), .pulse(cancel_pulse));

    key_selector u_keys (
        .clk      (clk),
        .rst      (rst),
        .key_req  (key_req),
        .key_code (key_code),
        .key_ack  (key_ack),
        .select   (select)
    );

    vend_core u_core (
        .clk         (clk),
        .rst         (rst),
        .add_5       (add_5),
        .add_10      (add_10),
        .add_50      (add_50),
        .cancel      (cancel_pulse),
        .select      (select),
        .return_tick (return_tick),
        .credit      (credit),
        .affordable  (affordable),
        .dispense    (dispense),
        .coin_out    (coin_out),
        .busy        (busy)
    );

    // coin return pacing, only runs while paying back
    tick_divider #(.DIV_COUNT(RETURN_DIV)) u_return_div (
        .clk  (clk),
        .rst  (rst),
        .run  (busy),
        .tick (return_tick)
    );

    coin_display #(.SCAN_DIV(SCAN_DIV)) u_display (
        .clk    (clk),
        .rst    (rst),
        .credit (credit),
        .seg    (seg),
        .an     (an)
    );

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 8,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset drops on a rising edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== test/vend_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module vend_tb;

    localparam int return_div = 16;
    localparam int scan_div = 4;
    localparam int press_cycles = vend_pkg::debounce_len + 4;
    localparam int line_budget = 20 * return_div + 200;

    localparam int btn_5 = 0;
    localparam int btn_10 = 1;
    localparam int btn_50 = 2;
    localparam int btn_cancel = 3;

    logic clk;
    logic rst;
    logic coin_5;
    logic coin_10;
    logic coin_50;
    logic cancel;
    logic key_req;
    logic [7:0] key_code;
    logic key_ack;
    logic [vend_pkg::n_drinks-1:0] dispense;
    logic coin_out;
    logic busy;
    logic [vend_pkg::n_drinks-1:0] affordable;
    logic [7:0] seg;
    logic [3:0] an;

    // one entry per test data line
    string names [$];
    string ops [$];
    string args [$];
    int exp_credit [$];
    int exp_afford [$];
    int exp_disp [$];
    int exp_coins [$];

    int coin_count;
    int disp_count [vend_pkg::n_drinks];
    int cycle_count = 0;
    int cycle_limit = 0;

    tb_clock #(.PERIOD_NS(8), .RESET_CYCLES(3)) u_clock (.clk(clk), .rst(rst));

    vend_top #(.RETURN_DIV(return_div), .SCAN_DIV(scan_div)) dut (
        .clk        (clk),
        .rst        (rst),
        .coin_5     (coin_5),
        .coin_10    (coin_10),
        .coin_50    (coin_50),
        .cancel     (cancel),
        .key_req    (key_req),
        .key_code   (key_code),
        .key_ack    (key_ack),
        .dispense   (dispense),
        .coin_out   (coin_out),
        .busy       (busy),
        .affordable (affordable),
        .seg        (seg),
        .an         (an)
    );

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            report_failure($sformatf("Mismatch in %s: expected %0d, actual %0d",
                name, expected, actual));
        end
    endtask

    // pulse monitors, sampled away from the driving edge
    always @(negedge clk) begin
        if (rst) begin
            coin_count <= 0;
            for (int i = 0; i < vend_pkg::n_drinks; i++) begin
                disp_count[i] <= 0;
            end
        end else begin
            if (coin_out) begin
                coin_count <= coin_count + 1;
            end
            for (int i = 0; i < vend_pkg::n_drinks; i++) begin
                if (dispense[i]) begin
                    disp_count[i] <= disp_count[i] + 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            report_failure($sformatf("Timeout: run went past %0d cycles", cycle_limit));
        end
    end

    task automatic load_tests;
        int fd;
        int fields;
        int disp_idx;
        int credit;
        int afford;
        int coins;
        string line;
        string name;
        string op;
        string arg;
        string disp;
        fd = $fopen("test/vend_testdata.txt", "r");
        if (fd == 0) begin
            report_failure("Could not open test/vend_testdata.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            fields = $fgets(line, fd);
            if (fields > 0 && line.substr(0, 0) != "#") begin
                fields = $sscanf(line, "%s %s %s %d %b %s %d",
                    name, op, arg, credit, afford, disp, coins);
                if (fields == 7) begin
                    disp_idx = -1;
                    if (disp != "none") begin
                        void'($sscanf(disp, "%d", disp_idx));
                    end
                    names.push_back(name);
                    ops.push_back(op);
                    args.push_back(arg);
                    exp_credit.push_back(credit);
                    exp_afford.push_back(afford);
                    exp_disp.push_back(disp_idx);
                    exp_coins.push_back(coins);
                end else if (fields > 0) begin
                    report_failure({"Malformed test data line: ", line});
                end
            end
        end
        $fclose(fd);
    endtask

    // seven-segment pattern back to a digit, 15 when unknown
    function automatic int decode_seg(input logic [7:0] pattern);
        int value;
        value = 15;
        for (int i = 0; i < 10; i++) begin
            if (vend_pkg::seg_table[i] == pattern) begin
                value = i;
            end
        end
        return value;
    endfunction

    task automatic read_credit(output int value);
        int ones;
        int tens;
        @(negedge clk);
        while (an !== 4'b1110) @(negedge clk);
        ones = decode_seg(seg);
        while (an !== 4'b1101) @(negedge clk);
        tens = decode_seg(seg);
        value = tens * 10 + ones;
    endtask

    task automatic wait_busy(input logic level);
        @(negedge clk);
        while (busy !== level) @(negedge clk);
    endtask

    task automatic wait_ack(input logic level);
        @(negedge clk);
        while (key_ack !== level) @(negedge clk);
    endtask

    task automatic press_button(input int btn);
        @(posedge clk);
        case (btn)
            btn_5: coin_5 <= 1'b1;
            btn_10: coin_10 <= 1'b1;
            btn_50: coin_50 <= 1'b1;
            default: cancel <= 1'b1;
        endcase
        repeat (press_cycles) @(posedge clk);
        coin_5 <= 1'b0;
        coin_10 <= 1'b0;
        coin_50 <= 1'b0;
        cancel <= 1'b0;
        repeat (press_cycles) @(posedge clk);
    endtask

    task automatic press_coin(input int value);
        if (value == 5) begin
            press_button(btn_5);
        end else if (value == 10) begin
            press_button(btn_10);
        end else if (value == 50) begin
            press_button(btn_50);
        end else begin
            report_failure($sformatf("Test data asks for an unknown coin of %0d", value));
        end
    endtask

    // four-phase handshake, code settles before req
    task automatic send_key(input logic [7:0] code);
        @(posedge clk);
        key_code <= code;
        @(posedge clk);
        key_req <= 1'b1;
        wait_ack(1'b1);
        @(posedge clk);
        key_req <= 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic run_line(input int k);
        int arg_value;
        int start_coins;
        int got_credit;
        int total_disp;
        int start_disp [vend_pkg::n_drinks];
        string name;
        name = names[k];
        start_coins = coin_count;
        for (int i = 0; i < vend_pkg::n_drinks; i++) begin
            start_disp[i] = disp_count[i];
        end
        arg_value = 0;
        if (ops[k] == "key" || ops[k] == "busy_key") begin
            void'($sscanf(args[k], "%h", arg_value));
        end else if (args[k] != "-") begin
            void'($sscanf(args[k], "%d", arg_value));
        end

        if (ops[k] == "coin") begin
            press_coin(arg_value);
        end else if (ops[k] == "cancel") begin
            press_button(btn_cancel);
        end else if (ops[k] == "key") begin
            send_key(8'(arg_value));
        end else if (ops[k] == "busy_coin") begin
            press_button(btn_cancel);
            wait_busy(1'b1);
            press_coin(arg_value);
        end else if (ops[k] == "busy_key") begin
            press_button(btn_cancel);
            wait_busy(1'b1);
            send_key(8'(arg_value));
        end else if (ops[k] != "check") begin
            report_failure({"Unknown operation in test data: ", ops[k]});
        end

        // return is over once busy drops
        wait_busy(1'b0);
        read_credit(got_credit);

        check_value({name, " credit"}, exp_credit[k], got_credit);
        check_value({name, " affordable"}, exp_afford[k], int'(affordable));
        check_value({name, " returned coins"}, exp_coins[k], coin_count - start_coins);
        total_disp = 0;
        for (int i = 0; i < vend_pkg::n_drinks; i++) begin
            total_disp = total_disp + disp_count[i] - start_disp[i];
        end
        check_value({name, " dispense count"}, (exp_disp[k] < 0) ? 0 : 1, total_disp);
        if (exp_disp[k] >= 0) begin
            check_value({name, " dispense line"}, 1,
                disp_count[exp_disp[k]] - start_disp[exp_disp[k]]);
        end
    endtask

    initial begin
        coin_5 = 1'b0;
        coin_10 = 1'b0;
        coin_50 = 1'b0;
        cancel = 1'b0;
        key_req = 1'b0;
        key_code = 8'h00;
        void'($urandom(32'hf5c6_d1eb));

        load_tests();
        if (names.size() == 0) begin
            report_failure("No tests were found in the test data file");
        end
        cycle_limit = names.size() * line_budget;

        @(negedge clk);
        while (rst) @(negedge clk);
        // state right after reset, ones digit first
        check_value("reset busy", 0, int'(busy));
        check_value("reset key_ack", 0, int'(key_ack));
        check_value("reset coin_out", 0, int'(coin_out));
        check_value("reset dispense", 0, int'(dispense));
        check_value("reset affordable", 0, int'(affordable));
        check_value("reset an", 14, int'(an));

        for (int k = 0; k < names.size(); k++) begin
            repeat ($urandom_range(7, 0)) @(posedge clk);
            run_line(k);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/vend_testdata.txt ====
# name op arg credit affordable(ASDF) dispense(bit index or none) returned_coins
# op: coin <value>, cancel -, key <hex code>, check -, busy_coin <value>, busy_key <hex code>
reset_state check - 0 0000 none 0
coin_5 coin 5 5 0000 none 0
coin_10 coin 10 15 0000 none 0
coin_50 coin 50 65 1111 none 0
coin_to_cap coin 50 95 1111 none 0
cap_holds coin 5 95 1111 none 0
buy_a key 1C 0 0000 3 7
unknown_zero key 1A 0 0000 none 0
cancel_zero cancel - 0 0000 none 0
coin_f1 coin 10 10 0000 none 0
coin_f2 coin 10 20 0001 none 0
buy_f_exact key 2B 0 0000 0 0
coin_d1 coin 50 50 0111 none 0
buy_a_short key 1C 50 0111 none 0
unknown_key key 15 50 0111 none 0
buy_d key 23 0 0000 1 5
coin_s1 coin 10 10 0000 none 0
coin_s2 coin 10 20 0001 none 0
coin_s3 coin 10 30 0111 none 0
buy_s_exact key 1B 0 0000 2 0
coin_c1 coin 5 5 0000 none 0
coin_c2 coin 50 55 0111 none 0
cancel_55 cancel - 0 0000 none 11
coin_b1 coin 50 50 0111 none 0
coin_b2 coin 10 60 1111 none 0
busy_coin busy_coin 50 0 0000 none 12
coin_b3 coin 50 50 0111 none 0
busy_key busy_key 2B 0 0000 none 10
coin_e1 coin 10 10 0000 none 0
coin_e2 coin 5 15 0000 none 0
coin_e3 coin 10 25 0011 none 0
buy_f key 2B 0 0000 0 1
final_check check - 0 0000 none 0

// ==== flist.f ====
rtl/vend_pkg.sv
rtl/debounce_pulse.sv
rtl/tick_divider.sv
rtl/key_selector.sv
rtl/vend_core.sv
rtl/coin_display.sv
rtl/vend_top.sv
test/tb_clock.sv
test/vend_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the vending controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns -j 0 \
    --top-module vend_tb -f flist.f --Mdir obj_dir -o vend_sim

# the simulator exits nonzero on a fatal error, the log decides the result
./obj_dir/vend_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "run failed"
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "run ended without a result"
    exit 1
fi
echo "run passed"
